/* rtl/rename_pkg.sv */
package rename_pkg;

	// ##########################################################
	// register file sizes
	// ##########################################################
	localparam int NUM_ARCH_REGS = 32;
	localparam int NUM_PHYS_REGS = 64;
	localparam int FREE_REGS     = NUM_PHYS_REGS - NUM_ARCH_REGS; // also decoder credits

	localparam int ARCH_W = $clog2(NUM_ARCH_REGS);  // 5
	localparam int PHYS_W = $clog2(NUM_PHYS_REGS);  // 6
	localparam int ACT_W  = ARCH_W + PHYS_W;        // {arch rd, old phys}
	localparam int CNT_W  = $clog2(FREE_REGS + 1);  // fifo occupancy, 0..FREE_REGS

	localparam logic [5:0] OP_RTYPE = 6'd0;

	// ##########################################################
	// instruction word, two decodes of the same 32 bits
	// ##########################################################
	typedef union packed {
		struct packed {
			logic [5:0]        op;
			logic [ARCH_W-1:0] rs;
			logic [ARCH_W-1:0] rt;
			logic [ARCH_W-1:0] rd;    // dest for r-type
			logic [4:0]        shamt;
			logic [5:0]        funct;
		} r;
		struct packed {
			logic [5:0]        op;
			logic [ARCH_W-1:0] rs;
			logic [ARCH_W-1:0] rt;    // dest for i-type
			logic [15:0]       imm;
		} i;
	} instr_u;

endpackage

/* rtl/fifo_if.sv */
interface fifo_if
	import rename_pkg::*;
#(
	parameter int WIDTH = 8
) ();

	// user side
	logic             push;
	logic [WIDTH-1:0] push_data;
	logic             pop;      // only while !empty

	// fifo side
	logic [WIDTH-1:0] pop_data; // head entry, combinational
	logic             empty;
	logic [CNT_W-1:0] count;

	modport store (
		input  push, push_data, pop,
		output pop_data, empty, count
	);

	modport user (
		output push, push_data, pop,
		input  pop_data, empty, count
	);

endinterface

/* rtl/circ_fifo.sv */
module circ_fifo
	import rename_pkg::*;
#(
	parameter int WIDTH      = 6,
	parameter int DEPTH      = 32,
	parameter int INIT_FIRST = -1  // <0 resets empty, else preload INIT_FIRST+i
) (
	input logic   clk,
	input logic   rst,
	fifo_if.store f
);

	localparam int PTR_W = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] head;  // oldest entry
	logic [PTR_W-1:0] tail;  // next free slot
	logic [CNT_W-1:0] count;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ##########################################################
	// pointers and occupancy
	// ##########################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			head  <= '0;
			tail  <= '0;  // full preload wraps tail back onto head
			count <= (INIT_FIRST < 0) ? '0 : CNT_W'(DEPTH);
		end else begin
			if (f.pop)
				head <= ptr_inc(head);
			if (f.push)
				tail <= ptr_inc(tail);
			case ({f.push, f.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	// ##########################################################
	// storage
	// ##########################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			if (INIT_FIRST >= 0) begin
				// free list starts as INIT_FIRST, INIT_FIRST+1, ...
				for (int i = 0; i < DEPTH; i++)
					mem[i] <= WIDTH'(INIT_FIRST + i);
			end
		end else if (f.push) begin
			mem[tail] <= f.push_data;  // push to a full fifo never happens here
		end
	end

	assign f.pop_data = mem[head];  // show-ahead
	assign f.empty    = (count == '0);
	assign f.count    = count;

endmodule

/* rtl/map_table.sv */
module map_table
	import rename_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic [ARCH_W-1:0] rs_arch,
	input  logic [ARCH_W-1:0] rt_arch,
	input  logic [ARCH_W-1:0] rd_arch,
	output logic [PHYS_W-1:0] rs_phys,
	output logic [PHYS_W-1:0] rt_phys,
	output logic [PHYS_W-1:0] rd_old_phys,
	input  logic              wr_en,
	input  logic [ARCH_W-1:0] wr_arch,
	input  logic [PHYS_W-1:0] wr_phys
);

	logic [PHYS_W-1:0] map [NUM_ARCH_REGS];  // arch -> phys

	// ##########################################################
	// write port
	// ##########################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			// identity, arch i lives in phys i
			for (int i = 0; i < NUM_ARCH_REGS; i++)
				map[i] <= PHYS_W'(i);
		end else if (wr_en) begin
			map[wr_arch] <= wr_phys;
		end
	end

	// ##########################################################
	// read ports
	// ##########################################################
	// flop array, so a same-cycle write is seen only after the edge
	assign rs_phys     = map[rs_arch];
	assign rt_phys     = map[rt_arch];
	assign rd_old_phys = map[rd_arch];  // mapping being replaced

endmodule

/* rtl/rename_stage.sv */
module rename_stage
	import rename_pkg::*;
(
	input  logic              clk,
	input  logic              rst,

	// decoder side
	input  logic              dec_valid,
	input  instr_u            dec_instr,

	// renamed instruction
	output logic              ren_valid,
	output logic [PHYS_W-1:0] ren_rs_phys,
	output logic [PHYS_W-1:0] ren_rt_phys,
	output logic [PHYS_W-1:0] ren_rd_phys,
	output logic [PHYS_W-1:0] ren_old_phys,

	// retire side
	input  logic              commit_valid,
	output logic              commit_done,
	output logic [ARCH_W-1:0] commit_arch,
	output logic [PHYS_W-1:0] commit_phys,
	output logic              credit_return,

	fifo_if.user              free_q,
	fifo_if.user              act_q,

	// map table
	output logic [ARCH_W-1:0] rs_arch,
	output logic [ARCH_W-1:0] rt_arch,
	output logic [ARCH_W-1:0] rd_arch,
	input  logic [PHYS_W-1:0] rs_phys,
	input  logic [PHYS_W-1:0] rt_phys,
	input  logic [PHYS_W-1:0] rd_old_phys,
	output logic              wr_en,
	output logic [ARCH_W-1:0] wr_arch,
	output logic [PHYS_W-1:0] wr_phys
);

	logic              do_ren;
	logic              do_commit;
	logic [ARCH_W-1:0] dst_arch;

	// ##########################################################
	// decode
	// ##########################################################
	// rs and rt sit in the same bits for both formats
	assign rs_arch  = dec_instr.r.rs;
	assign rt_arch  = dec_instr.r.rt;
	assign dst_arch = (dec_instr.r.op == OP_RTYPE) ? dec_instr.r.rd : dec_instr.i.rt;
	assign rd_arch  = dst_arch;

	// credits keep the free list non-empty, empty check is a backstop
	assign do_ren    = dec_valid && !free_q.empty;
	assign do_commit = commit_valid && !act_q.empty;  // empty active list ignored

	// ##########################################################
	// allocate and update map
	// ##########################################################
	assign free_q.pop = do_ren;
	assign wr_en      = do_ren;
	assign wr_arch    = dst_arch;
	assign wr_phys    = free_q.pop_data;  // new dest phys

	assign act_q.push      = do_ren;
	assign act_q.push_data = {dst_arch, rd_old_phys};  // arch rd, then old phys

	// retire oldest, its old phys goes back to the free list tail
	assign act_q.pop        = do_commit;
	assign free_q.push      = do_commit;
	assign free_q.push_data = act_q.pop_data[PHYS_W-1:0];

	// ##########################################################
	// output registers
	// ##########################################################
	always_ff @(posedge clk) begin
		if (rst) begin
			ren_valid     <= 1'b0;
			commit_done   <= 1'b0;
			credit_return <= 1'b0;
		end else begin
			ren_valid     <= do_ren;
			commit_done   <= do_commit;
			credit_return <= do_commit;  // one credit per freed reg
		end
	end

	// payload, qualified by the valids above
	always_ff @(posedge clk) begin
		if (do_ren) begin
			ren_rs_phys  <= rs_phys;
			ren_rt_phys  <= rt_phys;
			ren_rd_phys  <= free_q.pop_data;
			ren_old_phys <= rd_old_phys;
		end
		if (do_commit) begin
			commit_arch <= act_q.pop_data[ACT_W-1 -: ARCH_W];
			commit_phys <= act_q.pop_data[PHYS_W-1:0];
		end
	end

endmodule

/* rtl/rename_top.sv */
module rename_top
	import rename_pkg::*;
(
	input  logic              clk,
	input  logic              rst,

	input  logic              dec_valid,
	input  instr_u            dec_instr,

	output logic              ren_valid,
	output logic [PHYS_W-1:0] ren_rs_phys,
	output logic [PHYS_W-1:0] ren_rt_phys,
	output logic [PHYS_W-1:0] ren_rd_phys,
	output logic [PHYS_W-1:0] ren_old_phys,

	input  logic              commit_valid,
	output logic              commit_done,
	output logic [ARCH_W-1:0] commit_arch,
	output logic [PHYS_W-1:0] commit_phys,
	output logic              credit_return
);

	// map table wires
	logic [ARCH_W-1:0] rs_arch;
	logic [ARCH_W-1:0] rt_arch;
	logic [ARCH_W-1:0] rd_arch;
	logic [PHYS_W-1:0] rs_phys;
	logic [PHYS_W-1:0] rt_phys;
	logic [PHYS_W-1:0] rd_old_phys;
	logic              wr_en;
	logic [ARCH_W-1:0] wr_arch;
	logic [PHYS_W-1:0] wr_phys;

	fifo_if #(.WIDTH(PHYS_W)) free_q ();  // free phys regs
	fifo_if #(.WIDTH(ACT_W))  act_q ();   // in-flight renames, oldest first

	// ##########################################################
	// instances
	// ##########################################################
	rename_stage stage_i (
		.clk, .rst,
		.dec_valid, .dec_instr,
		.ren_valid, .ren_rs_phys, .ren_rt_phys, .ren_rd_phys, .ren_old_phys,
		.commit_valid, .commit_done, .commit_arch, .commit_phys, .credit_return,
		.free_q (free_q.user),
		.act_q  (act_q.user),
		.rs_arch, .rt_arch, .rd_arch,
		.rs_phys, .rt_phys, .rd_old_phys,
		.wr_en, .wr_arch, .wr_phys
	);

	map_table map_i (
		.clk, .rst,
		.rs_arch, .rt_arch, .rd_arch,
		.rs_phys, .rt_phys, .rd_old_phys,
		.wr_en, .wr_arch, .wr_phys
	);

	// preloaded with phys 32..63
	circ_fifo #(.WIDTH(PHYS_W), .DEPTH(FREE_REGS), .INIT_FIRST(NUM_ARCH_REGS)) free_fifo (
		.clk, .rst,
		.f (free_q.store)
	);

	circ_fifo #(.WIDTH(ACT_W), .DEPTH(FREE_REGS), .INIT_FIRST(-1)) active_fifo (
		.clk, .rst,
		.f (act_q.store)
	);

endmodule

/* tb/rename_checker.sv */
module rename_checker
	import rename_pkg::*;
(
	input  logic              clk,
	input  logic              rst,
	input  logic              dec_valid,
	input  instr_u            dec_instr,
	input  logic              commit_valid,
	input  logic              ren_valid,
	input  logic [PHYS_W-1:0] ren_rs_phys,
	input  logic [PHYS_W-1:0] ren_rt_phys,
	input  logic [PHYS_W-1:0] ren_rd_phys,
	input  logic [PHYS_W-1:0] ren_old_phys,
	input  logic              commit_done,
	input  logic [ARCH_W-1:0] commit_arch,
	input  logic [PHYS_W-1:0] commit_phys,
	input  logic              credit_return,
	input  logic              row_check,        // compare credit balance this edge
	input  int                row_exp_credits,
	output int                errors
);

	timeunit 1ns;
	timeprecision 100ps;

	// ##########################################################
	// reference model state
	// ##########################################################
	logic [PHYS_W-1:0] map_ref [NUM_ARCH_REGS];
	logic [PHYS_W-1:0] free_ref [$];  // head is next allocation
	logic [ACT_W-1:0]  act_ref [$];   // oldest first
	bit                live;          // out of reset, sampled at posedge
	bit                exp_ren;
	bit                exp_commit;
	logic [PHYS_W-1:0] e_rs, e_rt, e_rd, e_old, e_cphys;
	logic [ARCH_W-1:0] e_carch;
	int                renames;       // dec_valid seen
	int                returns;       // credit_return pulses seen
	int                err_cred;
	int                err_cmp;

	assign errors = err_cred + err_cmp;

	task automatic compare(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
		if (exp_v !== act_v) begin
			$display("** Error %s: expected %h, got %h", name, exp_v, act_v);
			err_cmp++;
		end
	endtask

	// inputs were driven on the falling edge, stable here
	always @(posedge clk) begin
		logic [ARCH_W-1:0] dst;
		bit                can_ren;
		bit                can_commit;
		live = !rst;
		if (rst) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++)
				map_ref[i] = PHYS_W'(i);  // identity
			free_ref.delete();
			for (int i = 0; i < FREE_REGS; i++)
				free_ref.push_back(PHYS_W'(NUM_ARCH_REGS + i));
			act_ref.delete();
			exp_ren    = 0;
			exp_commit = 0;
			renames    = 0;
			err_cred   = 0;
		end else begin
			// balance before this edge's request
			if (row_check && (FREE_REGS - renames + returns) != row_exp_credits) begin
				$display("** Error credits: expected %h, got %h", row_exp_credits,
					FREE_REGS - renames + returns);
				err_cred++;
			end
			can_ren    = dec_valid && free_ref.size() > 0;
			can_commit = commit_valid && act_ref.size() > 0;  // empty list ignored
			exp_ren    = can_ren;
			exp_commit = can_commit;
			if (dec_valid)
				renames++;
			if (can_commit) begin
				e_carch = act_ref[0][ACT_W-1 -: ARCH_W];
				e_cphys = act_ref[0][PHYS_W-1:0];
				void'(act_ref.pop_front());
				free_ref.push_back(e_cphys);  // back to the tail
			end
			if (can_ren) begin
				// r-type writes rd, everything else writes rt
				dst   = (dec_instr.r.op == OP_RTYPE) ? dec_instr.r.rd : dec_instr.i.rt;
				e_rs  = map_ref[dec_instr.r.rs];
				e_rt  = map_ref[dec_instr.r.rt];
				e_old = map_ref[dst];          // sources read before own write
				e_rd  = free_ref.pop_front();
				map_ref[dst] = e_rd;
				act_ref.push_back({dst, e_old});
			end
		end
	end

	// registered outputs settle mid cycle
	always @(negedge clk) begin
		if (!live) begin
			returns = 0;
			err_cmp = 0;
		end else begin
			if (credit_return)
				returns++;
			if (ren_valid && !exp_ren) begin
				$display("ren_valid pulsed although no instruction was sent");
				err_cmp++;
			end else if (exp_ren && !ren_valid) begin
				$display("ren_valid stayed low for an accepted instruction");
				err_cmp++;
			end else if (exp_ren) begin
				compare("ren_rs_phys", 8'(e_rs), 8'(ren_rs_phys));
				compare("ren_rt_phys", 8'(e_rt), 8'(ren_rt_phys));
				compare("ren_rd_phys", 8'(e_rd), 8'(ren_rd_phys));
				compare("ren_old_phys", 8'(e_old), 8'(ren_old_phys));
			end
			if (commit_done && !exp_commit) begin
				$display("commit_done pulsed although nothing could retire");
				err_cmp++;
			end else if (exp_commit && !commit_done) begin
				$display("commit_done stayed low for a valid commit");
				err_cmp++;
			end else if (exp_commit) begin
				compare("commit_arch", 8'(e_carch), 8'(commit_arch));
				compare("commit_phys", 8'(e_cphys), 8'(commit_phys));
			end
			compare("credit_return", 8'(exp_commit), 8'(credit_return));
		end
	end

endmodule

/* tb/tb_rename.sv */
module tb_rename
	import rename_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] SEED   = 32'h1b48_a16f;
	localparam int          MARGIN = 100;  // extra timeout cycles
	localparam logic [1:0]  IDLE   = 2'd0;
	localparam logic [1:0]  REN    = 2'd1;
	localparam logic [1:0]  COM    = 2'd2;
	localparam logic [1:0]  BOTH   = 2'd3;

	typedef struct {
		string       desc;
		logic [1:0]  op;       // bit 0 rename, bit 1 commit
		logic [31:0] instr;
		int          rep;
		bit          rnd;      // fresh random r-type each repeat
		int          credits;  // expected credit balance after the row
	} row_t;

	logic              clk;
	logic              rst;
	logic              dec_valid;
	instr_u            dec_instr;
	logic              commit_valid;
	logic              ren_valid;
	logic [PHYS_W-1:0] ren_rs_phys;
	logic [PHYS_W-1:0] ren_rt_phys;
	logic [PHYS_W-1:0] ren_rd_phys;
	logic [PHYS_W-1:0] ren_old_phys;
	logic              commit_done;
	logic [ARCH_W-1:0] commit_arch;
	logic [PHYS_W-1:0] commit_phys;
	logic              credit_return;
	logic              row_check;
	int                row_exp_credits;
	int                errors;

	row_t        tbl [$];
	logic [31:0] lcg_state;
	int          credits;     // decoder credit counter
	int          cycles = 0;
	int          limit = 0;

	rename_top dut_i (.*);
	rename_checker chk_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rtype(input logic [ARCH_W-1:0] rs, rt, rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, 6'h20};  // add
	endfunction

	function automatic logic [31:0] itype(input logic [5:0] op, input logic [ARCH_W-1:0] rs, rt,
		input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] random_rtype();
		logic [31:0] r;
		r = lcg_next();
		return rtype(r[31:27], r[26:22], r[21:17]);  // upper bits mix best
	endfunction

	task automatic add_row(input string desc, input logic [1:0] op, input logic [31:0] instr,
		input int rep, input bit rnd, input int cred);
		row_t row;
		row.desc    = desc;
		row.op      = op;
		row.instr   = instr;
		row.rep     = rep;
		row.rnd     = rnd;
		row.credits = cred;
		tbl.push_back(row);
	endtask

	// every falling edge goes through here so no credit pulse is missed
	task automatic next_cycle();
		@(negedge clk);
		if (credit_return)
			credits++;
	endtask

	// ############################################################
	// stimulus
	// ############################################################
	initial begin
		int held;
		int err_before;
		int total;
		rst             = 1'b1;
		dec_valid       = 1'b0;
		dec_instr       = '0;
		commit_valid    = 1'b0;
		row_check       = 1'b0;
		row_exp_credits = 0;
		lcg_state       = SEED;
		credits         = FREE_REGS;
		total           = 0;

		add_row("idle after reset", IDLE, '0, 3, 0, 32);
		add_row("first r-type after reset", REN, rtype(3, 4, 5), 1, 0, 31);
		add_row("reads previous dest", REN, rtype(5, 5, 6), 1, 0, 30);
		add_row("i-type, rd field 5 untouched", REN, itype(6'h08, 6, 7, 16'h2800), 1, 0, 29);
		add_row("r5 still maps to 32", REN, rtype(5, 7, 8), 1, 0, 28);
		add_row("random renames until dry", REN, '0, 28, 1, 0);
		add_row("no credits left", REN, '0, 4, 1, 0);
		add_row("commits in retire order", COM, '0, 6, 0, 6);
		add_row("renames reuse freed regs", REN, '0, 6, 1, 0);
		add_row("more commits", COM, '0, 4, 0, 4);
		add_row("rename and commit together", BOTH, '0, 10, 1, 4);
		add_row("drain past empty", COM, '0, 40, 0, 32);
		add_row("commit on empty list", COM, '0, 3, 0, 32);
		add_row("renames after drain", REN, '0, 2, 1, 30);

		foreach (tbl[r])
			total += tbl[r].rep;
		limit = total * 4 + MARGIN;

		repeat (5) @(posedge clk);
		next_cycle();
		rst = 1'b0;

		for (int r = 0; r < tbl.size(); r++) begin
			held       = 0;
			err_before = errors;
			for (int k = 0; k < tbl[r].rep; k++) begin
				next_cycle();
				dec_instr = tbl[r].rnd ? random_rtype() : tbl[r].instr;
				dec_valid = 1'b0;
				if (tbl[r].op[0]) begin
					if (credits > 0) begin
						dec_valid = 1'b1;
						credits--;
					end else begin
						held++;  // decoder must wait for a credit
					end
				end
				commit_valid = tbl[r].op[1];
			end
			next_cycle();
			dec_valid       = 1'b0;
			commit_valid    = 1'b0;
			row_exp_credits = tbl[r].credits;
			row_check       = 1'b1;
			next_cycle();
			row_check = 1'b0;
			@(posedge clk);  // checker counts are quiet here
			$display("test %0d (%s): %0d cycles, %0d held back, %0d errors", r, tbl[r].desc,
				tbl[r].rep, held, errors - err_before);
		end

		$display("%0d tests run, %0d errors", tbl.size(), errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// run length guard
	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: run did not finish within %0d cycles", limit);
			$display("Finished with errors");
			$finish;
		end
	end

endmodule

/* verilog.f */
rtl/rename_pkg.sv
rtl/fifo_if.sv
rtl/circ_fifo.sv
rtl/map_table.sv
rtl/rename_stage.sv
rtl/rename_top.sv
tb/rename_checker.sv
tb/tb_rename.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rename testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_rename \
	-Mdir obj_dir \
	-f verilog.f

out=$(./obj_dir/Vtb_rename)
echo "$out"

if grep -qx "Finished with no errors" <<< "$out"; then
	exit 0
else
	exit 1
fi
